// File: hw/submult_fmt_pkg.sv
package submult_fmt_pkg;

  // Data and grid samples
  localparam int data_width     = 16;
  localparam int data_frac_bits = 12;

  // Scale operand
  localparam int scale_width     = 16;
  localparam int scale_frac_bits = 12;

  // Output format
  localparam int rslt_width     = 16;
  localparam int rslt_frac_bits = 12;

  // Full signed product of difference and scale
  localparam int prod_width = data_width + scale_width;

  // Product bit that lines up with the result binary point
  localparam int rslt_lsb = data_frac_bits + scale_frac_bits - rslt_frac_bits;

  typedef logic signed [data_width-1:0]  sample_t;
  typedef logic signed [scale_width-1:0] scale_t;
  typedef logic signed [rslt_width-1:0]  rslt_t;
  typedef logic signed [prod_width-1:0]  prod_t;

endpackage

// File: hw/submult_stream_pkg.sv
package submult_stream_pkg;

  // Beat on the data or grid input
  typedef struct packed {
    submult_fmt_pkg::sample_t value;
    logic                     last;
  } sample_beat_t;

  // Beat on the scale input
  typedef struct packed {
    submult_fmt_pkg::scale_t value;
    logic                    last;
  } scale_beat_t;

  // Scale rides along with the difference to the multiplier
  typedef struct packed {
    submult_fmt_pkg::sample_t diff;
    submult_fmt_pkg::scale_t  scale;
    logic                     last;
  } diff_beat_t;

  // After the multiply stage
  typedef struct packed {
    submult_fmt_pkg::prod_t prod;
    logic                   last;
  } prod_beat_t;

endpackage

// File: hw/stream_skid.sv
`timescale 1ns/1ps

module stream_skid #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     skid_valid_next;
  logic     in_fire;
  logic     load_main;

  assign in_fire = in_valid & in_ready;

  // Main entry may take a new beat when empty or being drained
  assign load_main = !out_valid | out_ready;

  // Skid entry fills only when a beat arrives while the output stalls
  assign skid_valid_next = load_main ? 1'b0 : (skid_valid | in_fire);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (load_main) begin
        out_valid <= skid_valid | in_fire;
      end
      skid_valid <= skid_valid_next;
      in_ready   <= !skid_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_fire) begin
        out_data <= in_data;
      end
    end else if (in_fire) begin
      skid_data <= in_data;
    end
  end

  // Stalled output holds its beat
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && out_data == $past(out_data));

  // Ready drops once both entries hold a beat
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready && in_fire |=> !in_ready);

endmodule

// File: hw/frame_aligner.sv
`timescale 1ns/1ps

module frame_aligner (
  input  logic                     clk,
  input  logic                     reset,

  input  submult_fmt_pkg::sample_t data_tdata,
  input  logic                     data_tvalid,
  output logic                     data_tready,
  input  logic                     data_tlast,

  input  submult_fmt_pkg::sample_t grid_tdata,
  input  logic                     grid_tvalid,
  output logic                     grid_tready,
  input  logic                     grid_tlast,

  input  submult_fmt_pkg::scale_t  scale_tdata,
  input  logic                     scale_tvalid,
  output logic                     scale_tready,
  input  logic                     scale_tlast,

  output submult_fmt_pkg::sample_t join_data,
  output submult_fmt_pkg::sample_t join_grid,
  output submult_fmt_pkg::scale_t  join_scale,
  output logic                     join_last,
  output logic                     join_valid,
  input  logic                     join_ready
);

  submult_stream_pkg::sample_beat_t data_in;
  submult_stream_pkg::sample_beat_t data_head;
  submult_stream_pkg::sample_beat_t grid_in;
  submult_stream_pkg::sample_beat_t grid_head;
  submult_stream_pkg::scale_beat_t  scale_in;
  submult_stream_pkg::scale_beat_t  scale_head;

  logic data_head_valid;
  logic grid_head_valid;
  logic scale_head_valid;
  logic data_pop;
  logic grid_pop;
  logic scale_pop;
  logic join_fire;

  assign data_in  = '{value: data_tdata, last: data_tlast};
  assign grid_in  = '{value: grid_tdata, last: grid_tlast};
  assign scale_in = '{value: scale_tdata, last: scale_tlast};

  stream_skid #(
    .payload_t (submult_stream_pkg::sample_beat_t)
  ) u_data_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (data_in),
    .in_valid  (data_tvalid),
    .in_ready  (data_tready),
    .out_data  (data_head),
    .out_valid (data_head_valid),
    .out_ready (data_pop)
  );

  stream_skid #(
    .payload_t (submult_stream_pkg::sample_beat_t)
  ) u_grid_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (grid_in),
    .in_valid  (grid_tvalid),
    .in_ready  (grid_tready),
    .out_data  (grid_head),
    .out_valid (grid_head_valid),
    .out_ready (grid_pop)
  );

  stream_skid #(
    .payload_t (submult_stream_pkg::scale_beat_t)
  ) u_scale_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (scale_in),
    .in_valid  (scale_tvalid),
    .in_ready  (scale_tready),
    .out_data  (scale_head),
    .out_valid (scale_head_valid),
    .out_ready (scale_pop)
  );

  // Three-way join
  assign join_valid = data_head_valid & grid_head_valid & scale_head_valid;
  assign join_last  = data_head.last & grid_head.last & scale_head.last;
  assign join_fire  = join_valid & join_ready;

  // A stream sitting on its last beat repeats it until all three end
  assign data_pop  = join_fire & (!data_head.last | join_last);
  assign grid_pop  = join_fire & (!grid_head.last | join_last);
  assign scale_pop = join_fire & (!scale_head.last | join_last);

  assign join_data  = data_head.value;
  assign join_grid  = grid_head.value;
  assign join_scale = scale_head.value;

  // Held last beats survive the join untouched
  a_data_held: assert property (@(posedge clk) disable iff (reset)
    join_valid && !join_last && data_head.last
      |=> data_head_valid && data_head == $past(data_head));

  a_grid_held: assert property (@(posedge clk) disable iff (reset)
    join_valid && !join_last && grid_head.last
      |=> grid_head_valid && grid_head == $past(grid_head));

  a_scale_held: assert property (@(posedge clk) disable iff (reset)
    join_valid && !join_last && scale_head.last
      |=> scale_head_valid && scale_head == $past(scale_head));

endmodule

// File: hw/diff_scale_pipe.sv
`timescale 1ns/1ps

module diff_scale_pipe (
  input  logic                     clk,
  input  logic                     reset,

  input  submult_fmt_pkg::sample_t join_data,
  input  submult_fmt_pkg::sample_t join_grid,
  input  submult_fmt_pkg::scale_t  join_scale,
  input  logic                     join_last,
  input  logic                     join_valid,
  output logic                     join_ready,

  output submult_fmt_pkg::rslt_t   rslt_tdata,
  output logic                     rslt_tvalid,
  output logic                     rslt_tlast,
  input  logic                     rslt_tready
);

  submult_stream_pkg::diff_beat_t diff_in;
  submult_stream_pkg::diff_beat_t diff_out;
  submult_stream_pkg::prod_beat_t prod_in;
  submult_stream_pkg::prod_beat_t prod_out;

  logic diff_valid;
  logic diff_ready;

  // Subtract stage wraps at the sample width
  assign diff_in = '{
    diff:  submult_fmt_pkg::sample_t'(join_data - join_grid),
    scale: join_scale,
    last:  join_last
  };

  stream_skid #(
    .payload_t (submult_stream_pkg::diff_beat_t)
  ) u_diff_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (diff_in),
    .in_valid  (join_valid),
    .in_ready  (join_ready),
    .out_data  (diff_out),
    .out_valid (diff_valid),
    .out_ready (diff_ready)
  );

  // Multiply stage keeps the full signed product
  assign prod_in = '{
    prod: submult_fmt_pkg::prod_t'(diff_out.diff) * submult_fmt_pkg::prod_t'(diff_out.scale),
    last: diff_out.last
  };

  stream_skid #(
    .payload_t (submult_stream_pkg::prod_beat_t)
  ) u_prod_skid (
    .clk       (clk),
    .reset     (reset),
    .in_data   (prod_in),
    .in_valid  (diff_valid),
    .in_ready  (diff_ready),
    .out_data  (prod_out),
    .out_valid (rslt_tvalid),
    .out_ready (rslt_tready)
  );

  // Slice at the output binary point drops the top bits
  assign rslt_tdata = prod_out.prod[submult_fmt_pkg::rslt_lsb +: submult_fmt_pkg::rslt_width];
  assign rslt_tlast = prod_out.last;

endmodule

// File: hw/submult.sv
`timescale 1ns/1ps

module submult (
  input  logic                     clk,
  input  logic                     reset,

  input  submult_fmt_pkg::sample_t data_tdata,
  input  logic                     data_tvalid,
  output logic                     data_tready,
  input  logic                     data_tlast,

  input  submult_fmt_pkg::sample_t grid_tdata,
  input  logic                     grid_tvalid,
  output logic                     grid_tready,
  input  logic                     grid_tlast,

  input  submult_fmt_pkg::scale_t  scale_tdata,
  input  logic                     scale_tvalid,
  output logic                     scale_tready,
  input  logic                     scale_tlast,

  output submult_fmt_pkg::rslt_t   rslt_tdata,
  output logic                     rslt_tvalid,
  input  logic                     rslt_tready,
  output logic                     rslt_tlast
);

  submult_fmt_pkg::sample_t join_data;
  submult_fmt_pkg::sample_t join_grid;
  submult_fmt_pkg::scale_t  join_scale;
  logic                     join_last;
  logic                     join_valid;
  logic                     join_ready;

  frame_aligner u_aligner (
    .clk          (clk),
    .reset        (reset),
    .data_tdata   (data_tdata),
    .data_tvalid  (data_tvalid),
    .data_tready  (data_tready),
    .data_tlast   (data_tlast),
    .grid_tdata   (grid_tdata),
    .grid_tvalid  (grid_tvalid),
    .grid_tready  (grid_tready),
    .grid_tlast   (grid_tlast),
    .scale_tdata  (scale_tdata),
    .scale_tvalid (scale_tvalid),
    .scale_tready (scale_tready),
    .scale_tlast  (scale_tlast),
    .join_data    (join_data),
    .join_grid    (join_grid),
    .join_scale   (join_scale),
    .join_last    (join_last),
    .join_valid   (join_valid),
    .join_ready   (join_ready)
  );

  diff_scale_pipe u_pipe (
    .clk         (clk),
    .reset       (reset),
    .join_data   (join_data),
    .join_grid   (join_grid),
    .join_scale  (join_scale),
    .join_last   (join_last),
    .join_valid  (join_valid),
    .join_ready  (join_ready),
    .rslt_tdata  (rslt_tdata),
    .rslt_tvalid (rslt_tvalid),
    .rslt_tlast  (rslt_tlast),
    .rslt_tready (rslt_tready)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: sim/submult_checker.sv
`timescale 1ns/1ps

module submult_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  submult_fmt_pkg::sample_t data_tdata,
  input  logic                     data_tvalid,
  input  logic                     data_tready,
  input  logic                     data_tlast,
  input  submult_fmt_pkg::sample_t grid_tdata,
  input  logic                     grid_tvalid,
  input  logic                     grid_tready,
  input  logic                     grid_tlast,
  input  submult_fmt_pkg::scale_t  scale_tdata,
  input  logic                     scale_tvalid,
  input  logic                     scale_tready,
  input  logic                     scale_tlast,
  input  submult_fmt_pkg::rslt_t   rslt_tdata,
  input  logic                     rslt_tvalid,
  input  logic                     rslt_tready,
  input  logic                     rslt_tlast,
  output int                       beat_count,
  output int                       last_count,
  output int                       error_count
);

  // Accepted input beats as {value, last}
  logic [submult_fmt_pkg::data_width:0]  data_q[$];
  logic [submult_fmt_pkg::data_width:0]  grid_q[$];
  logic [submult_fmt_pkg::scale_width:0] scale_q[$];

  logic signed [submult_fmt_pkg::data_width-1:0]  exp_diff;
  logic signed [submult_fmt_pkg::scale_width-1:0] exp_scale;
  logic signed [submult_fmt_pkg::prod_width-1:0]  exp_prod;
  logic [submult_fmt_pkg::rslt_width-1:0]         exp_rslt;
  logic                                           all_last;
  int                                             frame_beat;

  initial begin
    beat_count  = 0;
    last_count  = 0;
    error_count = 0;
    frame_beat  = 0;
  end

  always @(posedge clk) begin
    if (reset) begin
      if (rslt_tvalid) begin
        $display("rslt_tvalid is high during reset");
        error_count++;
      end
    end else begin
      if (data_tvalid && data_tready) data_q.push_back({data_tdata, data_tlast});
      if (grid_tvalid && grid_tready) grid_q.push_back({grid_tdata, grid_tlast});
      if (scale_tvalid && scale_tready) scale_q.push_back({scale_tdata, scale_tlast});

      if (rslt_tvalid && rslt_tready) begin
        if (data_q.size() == 0 || grid_q.size() == 0 || scale_q.size() == 0) begin
          $display("output beat %0d arrived with no matching input beats", beat_count);
          error_count++;
        end else begin
          // Difference wraps at the sample width and the result starts at the binary point
          all_last  = data_q[0][0] & grid_q[0][0] & scale_q[0][0];
          exp_diff  = data_q[0][submult_fmt_pkg::data_width:1]
                      - grid_q[0][submult_fmt_pkg::data_width:1];
          exp_scale = scale_q[0][submult_fmt_pkg::scale_width:1];
          exp_prod  = submult_fmt_pkg::prod_t'(exp_diff) * submult_fmt_pkg::prod_t'(exp_scale);
          exp_rslt  = exp_prod[submult_fmt_pkg::rslt_lsb +: submult_fmt_pkg::rslt_width];
          if (rslt_tdata !== exp_rslt) begin
            $display("error frame %0d beat %0d data: expected %h, actual %h",
                     last_count, frame_beat, exp_rslt, rslt_tdata);
            error_count++;
          end
          if (rslt_tlast !== all_last) begin
            $display("error frame %0d beat %0d last: expected %b, actual %b",
                     last_count, frame_beat, all_last, rslt_tlast);
            error_count++;
          end
          // Shorter frames keep repeating their last beat
          if (!data_q[0][0] || all_last) void'(data_q.pop_front());
          if (!grid_q[0][0] || all_last) void'(grid_q.pop_front());
          if (!scale_q[0][0] || all_last) void'(scale_q.pop_front());
        end
        beat_count++;
        frame_beat++;
        if (rslt_tlast) begin
          last_count++;
          frame_beat = 0;
        end
      end
    end
  end

endmodule

// File: sim/tb_submult.sv
`timescale 1ns/1ps

module tb_submult;

  localparam int n_frames = 8;
  localparam int wait_limit = 300;

  logic clk;
  logic reset;

  submult_fmt_pkg::sample_t data_tdata;
  logic                     data_tvalid;
  logic                     data_tready;
  logic                     data_tlast;
  submult_fmt_pkg::sample_t grid_tdata;
  logic                     grid_tvalid;
  logic                     grid_tready;
  logic                     grid_tlast;
  submult_fmt_pkg::scale_t  scale_tdata;
  logic                     scale_tvalid;
  logic                     scale_tready;
  logic                     scale_tlast;
  submult_fmt_pkg::rslt_t   rslt_tdata;
  logic                     rslt_tvalid;
  logic                     rslt_tready;
  logic                     rslt_tlast;

  int beat_count;
  int last_count;
  int chk_errors;
  int tb_errors;
  int total_beats;

  logic [31:0] lfsr_state = 32'h317aaccd;

  // Per frame lengths and bases of data, grid and scale with random flag and output length
  int frame_len [n_frames][3] = '{
    '{4, 4, 4}, '{5, 5, 5}, '{6, 6, 6}, '{7, 3, 2},
    '{2, 8, 4}, '{3, 1, 9}, '{1, 1, 1}, '{10, 10, 10}
  };
  logic [15:0] frame_base [n_frames][3] = '{
    '{16'h1000, 16'h0800, 16'h2000}, '{16'h7ff0, 16'h8010, 16'hf000},
    '{16'h0000, 16'h0000, 16'h0000}, '{16'h0000, 16'h0000, 16'h0000},
    '{16'h0000, 16'h0000, 16'h0000}, '{16'h0000, 16'h0000, 16'h0000},
    '{16'hc000, 16'h3000, 16'he800}, '{16'h0000, 16'h0000, 16'h0000}
  };
  bit frame_rand [n_frames] = '{0, 0, 1, 1, 1, 1, 0, 1};
  int exp_len    [n_frames] = '{4, 5, 6, 7, 8, 9, 1, 10};
  logic [15:0] value_step [3] = '{16'h0123, 16'h0040, 16'h0100};

  logic [15:0] beat_vals [3][$];
  bit          beat_lasts[3][$];
  int          beat_gaps [3][$];

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  submult u_dut (
    .clk          (clk),
    .reset        (reset),
    .data_tdata   (data_tdata),
    .data_tvalid  (data_tvalid),
    .data_tready  (data_tready),
    .data_tlast   (data_tlast),
    .grid_tdata   (grid_tdata),
    .grid_tvalid  (grid_tvalid),
    .grid_tready  (grid_tready),
    .grid_tlast   (grid_tlast),
    .scale_tdata  (scale_tdata),
    .scale_tvalid (scale_tvalid),
    .scale_tready (scale_tready),
    .scale_tlast  (scale_tlast),
    .rslt_tdata   (rslt_tdata),
    .rslt_tvalid  (rslt_tvalid),
    .rslt_tready  (rslt_tready),
    .rslt_tlast   (rslt_tlast)
  );

  submult_checker u_chk (
    .clk          (clk),
    .reset        (reset),
    .data_tdata   (data_tdata),
    .data_tvalid  (data_tvalid),
    .data_tready  (data_tready),
    .data_tlast   (data_tlast),
    .grid_tdata   (grid_tdata),
    .grid_tvalid  (grid_tvalid),
    .grid_tready  (grid_tready),
    .grid_tlast   (grid_tlast),
    .scale_tdata  (scale_tdata),
    .scale_tvalid (scale_tvalid),
    .scale_tready (scale_tready),
    .scale_tlast  (scale_tlast),
    .rslt_tdata   (rslt_tdata),
    .rslt_tvalid  (rslt_tvalid),
    .rslt_tready  (rslt_tready),
    .rslt_tlast   (rslt_tlast),
    .beat_count   (beat_count),
    .last_count   (last_count),
    .error_count  (chk_errors)
  );

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic build_beats();
    logic [15:0] v;
    for (int f = 0; f < n_frames; f++) begin
      total_beats += exp_len[f];
      for (int s = 0; s < 3; s++) begin
        for (int i = 0; i < frame_len[f][s]; i++) begin
          if (frame_rand[f]) v = 16'(take_bits(16));
          else v = frame_base[f][s] + 16'(i) * value_step[s];
          beat_vals[s].push_back(v);
          beat_lasts[s].push_back(i == frame_len[f][s] - 1);
          // Roughly one beat in four gets an idle gap
          if (take_bits(2) == 0) beat_gaps[s].push_back(int'(take_bits(2)) + 1);
          else beat_gaps[s].push_back(0);
        end
      end
    end
  endtask

  task automatic set_beat(input int s, input logic valid, input logic [15:0] v, input bit l);
    case (s)
      0: begin
        data_tvalid <= valid;
        data_tdata  <= v;
        data_tlast  <= l;
      end
      1: begin
        grid_tvalid <= valid;
        grid_tdata  <= v;
        grid_tlast  <= l;
      end
      default: begin
        scale_tvalid <= valid;
        scale_tdata  <= v;
        scale_tlast  <= l;
      end
    endcase
  endtask

  function automatic logic ready_of(input int s);
    case (s)
      0: return data_tready;
      1: return grid_tready;
      default: return scale_tready;
    endcase
  endfunction

  task automatic drive_stream(input int s);
    int cnt;
    for (int i = 0; i < beat_vals[s].size(); i++) begin
      repeat (beat_gaps[s][i]) begin
        set_beat(s, 1'b0, beat_vals[s][i], 1'b0);
        @(posedge clk);
      end
      set_beat(s, 1'b1, beat_vals[s][i], beat_lasts[s][i]);
      cnt = 0;
      do begin
        @(posedge clk);
        cnt++;
      end while (!ready_of(s) && cnt < wait_limit);
      if (!ready_of(s)) begin
        $display("timeout: input stream %0d did not accept beat %0d", s, i);
        tb_errors++;
        break;
      end
    end
    set_beat(s, 1'b0, 16'h0000, 1'b0);
  endtask

  task automatic finish_run();
    $display("checker errors %0d, testbench errors %0d", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    int cnt;
    data_tdata   = '0;
    data_tvalid  = 1'b0;
    data_tlast   = 1'b0;
    grid_tdata   = '0;
    grid_tvalid  = 1'b0;
    grid_tlast   = 1'b0;
    scale_tdata  = '0;
    scale_tvalid = 1'b0;
    scale_tlast  = 1'b0;
    rslt_tready  = 1'b0;
    tb_errors    = 0;
    total_beats  = 0;
    build_beats();

    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (reset && cnt < wait_limit);
    if (reset) begin
      $display("timeout: reset never released");
      tb_errors++;
    end

    // Readies come up shortly after reset
    cnt = 0;
    while (!(data_tready && grid_tready && scale_tready) && cnt < 5) begin
      @(posedge clk);
      cnt++;
    end
    if (!(data_tready && grid_tready && scale_tready)) begin
      $display("timeout: input readies not high after reset");
      tb_errors++;
    end

    // No output without input
    repeat (4) begin
      @(posedge clk);
      if (rslt_tvalid) begin
        $display("rslt_tvalid high before any input was given");
        tb_errors++;
      end
    end

    fork
      forever begin
        rslt_tready <= (take_bits(2) != 0);
        @(posedge clk);
      end
    join_none

    fork
      drive_stream(0);
      drive_stream(1);
      drive_stream(2);
    join

    cnt = 0;
    while (beat_count < total_beats && cnt < wait_limit * 4) begin
      @(posedge clk);
      cnt++;
    end
    if (beat_count < total_beats) begin
      $display("timeout: %0d of %0d output beats seen", beat_count, total_beats);
      tb_errors++;
    end

    repeat (20) @(posedge clk);
    if (beat_count != total_beats) begin
      $display("error output beat count: expected %0d, actual %0d", total_beats, beat_count);
      tb_errors++;
    end
    if (last_count != n_frames) begin
      $display("error output frame count: expected %0d, actual %0d", n_frames, last_count);
      tb_errors++;
    end
    finish_run();
  end

endmodule

// File: sources.f
hw/submult_fmt_pkg.sv
hw/submult_stream_pkg.sv
hw/stream_skid.sv
hw/frame_aligner.sv
hw/diff_scale_pipe.sv
hw/submult.sv
sim/tb_clock.sv
sim/submult_checker.sv
sim/tb_submult.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_submult \
  -o Vtb_submult

./obj_dir/Vtb_submult | tee sim.log

if grep -q "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
